//--- include/int_div_params.svh
/*
  Width settings for the iterative divider. The step counter must be wide
  enough to count DIV_XLEN steps, so keep DIV_COUNT_W >= clog2(DIV_XLEN) + 1.
*/
`ifndef INT_DIV_PARAMS_SVH
`define INT_DIV_PARAMS_SVH

// ----------------------------------------------------------------------
// operand and counter widths
// ----------------------------------------------------------------------

// operand width, result is twice this
`define DIV_XLEN 32

// step counter width, one step per quotient bit
`define DIV_COUNT_W 6

`endif

//--- logic/int_div_pkg.sv
/*
  Shared types for the iterative divider. The state encoding is internal
  to the control unit and does not cross into the datapath.
*/
package int_div_pkg;

  // ----------------------------------------------------------------------
  // request function
  // ----------------------------------------------------------------------

  // one bit on the request, unsigned is zero
  typedef enum logic {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_fn_e;

  // ----------------------------------------------------------------------
  // control states
  // ----------------------------------------------------------------------

  // idle waits for a request, calc runs the steps,
  // done holds the response until it is taken
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } div_state_e;

endpackage

//--- logic/int_div_dpath.sv
/*
  Restoring divider datapath, one quotient bit per step_en. Needs exactly
  DIV_XLEN steps after load_en, with sign_en on the last. Divide by zero
  gives an all-ones magnitude quotient and the dividend as remainder.
*/
`timescale 1ns/1ns
`include "int_div_params.svh"

module int_div_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  int_div_pkg::div_fn_e      req_fn,
  input  logic [`DIV_XLEN-1:0]      req_a,
  input  logic [`DIV_XLEN-1:0]      req_b,
  input  logic                      load_en,
  input  logic                      step_en,
  input  logic                      sign_en,
  output logic [2*`DIV_XLEN-1:0]    resp_result
);

  localparam int XLEN = `DIV_XLEN;

  // ----------------------------------------------------------------------
  // operand magnitudes at the request
  // ----------------------------------------------------------------------

  logic            req_signed;
  logic            req_a_neg;
  logic            req_b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  // sign bits only count for the signed function
  assign req_signed = (req_fn == int_div_pkg::DIV_SIGNED);
  assign req_a_neg  = req_signed & req_a[XLEN-1];
  assign req_b_neg  = req_signed & req_b[XLEN-1];

  // two's complement negate where negative
  assign a_mag = req_a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b_neg ? (~req_b + 1'b1) : req_b;

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------

  int_div_pkg::div_fn_e fn_reg;
  logic                 sign_a_reg;
  logic                 sign_b_reg;
  logic [XLEN-1:0]      divisor_reg;
  // upper half is partial remainder, lower half dividend then quotient
  logic [2*XLEN-1:0]    acc_reg;
  logic [2*XLEN-1:0]    result_reg;

  // ----------------------------------------------------------------------
  // one shift-subtract step
  // ----------------------------------------------------------------------

  logic [XLEN:0]     partial;
  logic [XLEN+1:0]   diff;
  logic              borrow;
  logic [2*XLEN-1:0] acc_next;

  // shifted-up remainder, keeps the bit that leaves the top of acc
  assign partial = acc_reg[2*XLEN-1:XLEN-1];
  assign diff    = {1'b0, partial} - {2'b00, divisor_reg};
  assign borrow  = diff[XLEN+1];

  // no borrow: keep difference, quotient bit 1
  // borrow: restore shifted value, quotient bit 0
  assign acc_next = borrow ? {partial[XLEN-1:0], acc_reg[XLEN-2:0], 1'b0}
                           : {diff[XLEN-1:0], acc_reg[XLEN-2:0], 1'b1};

  // ----------------------------------------------------------------------
  // sign correction on the last step
  // ----------------------------------------------------------------------

  logic            fn_signed;
  logic            neg_quot;
  logic            neg_rem;
  logic [XLEN-1:0] quot_mag;
  logic [XLEN-1:0] rem_mag;
  logic [XLEN-1:0] quot_fix;
  logic [XLEN-1:0] rem_fix;

  assign fn_signed = (fn_reg == int_div_pkg::DIV_SIGNED);
  // quotient negative when signs differ
  assign neg_quot  = fn_signed & (sign_a_reg ^ sign_b_reg);
  // remainder follows the dividend
  assign neg_rem   = fn_signed & sign_a_reg;

  assign quot_mag = acc_next[XLEN-1:0];
  assign rem_mag  = acc_next[2*XLEN-1:XLEN];
  assign quot_fix = neg_quot ? (~quot_mag + 1'b1) : quot_mag;
  assign rem_fix  = neg_rem ? (~rem_mag + 1'b1) : rem_mag;

  // function and signs steer the correction
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg     <= int_div_pkg::DIV_UNSIGNED;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (load_en) begin
      fn_reg     <= req_fn;
      sign_a_reg <= req_a[XLEN-1];
      sign_b_reg <= req_b[XLEN-1];
    end
  end

  // operand and accumulator
  always_ff @(posedge clk) begin
    if (load_en) begin
      divisor_reg <= b_mag;
      acc_reg     <= {{XLEN{1'b0}}, a_mag};
    end else if (step_en) begin
      acc_reg <= acc_next;
    end
  end

  // result holds until the next division finishes
  always_ff @(posedge clk) begin
    if (sign_en) begin
      result_reg <= {rem_fix, quot_fix};
    end
  end

  assign resp_result = result_reg;

endmodule

//--- logic/int_div_ctrl.sv
/*
  Control for the iterative divider: one division at a time. CALC lasts
  DIV_XLEN cycles, the result is held in DONE until resp_rdy.
*/
`timescale 1ns/1ns
`include "int_div_params.svh"

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load_en,
  output logic step_en,
  output logic sign_en
);

  // count of the final step
  localparam logic [`DIV_COUNT_W-1:0] LAST_STEP = `DIV_COUNT_W'(`DIV_XLEN - 1);

  int_div_pkg::div_state_e   state;
  int_div_pkg::div_state_e   state_next;
  logic [`DIV_COUNT_W-1:0]   count;
  logic                      last_step;
  logic                      req_go;
  logic                      resp_go;

  // ----------------------------------------------------------------------
  // decoded outputs, state only
  // ----------------------------------------------------------------------

  assign req_rdy  = (state == int_div_pkg::IDLE);
  assign resp_val = (state == int_div_pkg::DONE);

  // handshakes
  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  assign last_step = (count == LAST_STEP);

  // datapath enables
  assign load_en = req_go;
  assign step_en = (state == int_div_pkg::CALC);
  // corrected result latched alongside the final step
  assign sign_en = step_en & last_step;

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      int_div_pkg::IDLE: begin
        if (req_go) begin
          state_next = int_div_pkg::CALC;
        end
      end
      int_div_pkg::CALC: begin
        if (last_step) begin
          state_next = int_div_pkg::DONE;
        end
      end
      int_div_pkg::DONE: begin
        // wait out back-pressure
        if (resp_go) begin
          state_next = int_div_pkg::IDLE;
        end
      end
      default: begin
        state_next = int_div_pkg::IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // state and step counter
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= int_div_pkg::IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      // restart at zero on accept, count up through calc
      if (load_en) begin
        count <= '0;
      end else if (step_en) begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

//--- logic/int_div_iterative.sv
/*
  Iterative 32-bit divider, val/rdy on both sides. Result is remainder in
  the upper half and quotient in the lower half; no divide-by-zero trap.
*/
`timescale 1ns/1ns
`include "int_div_params.svh"

module int_div_iterative (
  input  logic                      clk,
  input  logic                      reset,
  // request
  input  int_div_pkg::div_fn_e      req_fn,
  input  logic [`DIV_XLEN-1:0]      req_a,
  input  logic [`DIV_XLEN-1:0]      req_b,
  input  logic                      req_val,
  output logic                      req_rdy,
  // response
  output logic [2*`DIV_XLEN-1:0]    resp_result,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  // ----------------------------------------------------------------------
  // control to datapath
  // ----------------------------------------------------------------------

  logic load_en;
  logic step_en;
  logic sign_en;

  // registers, shift-subtract and sign fix
  int_div_dpath dpath_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .load_en     (load_en),
    .step_en     (step_en),
    .sign_en     (sign_en),
    .resp_result (resp_result)
  );

  // fsm, step count and handshake
  int_div_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load_en  (load_en),
    .step_en  (step_en),
    .sign_en  (sign_en)
  );

endmodule

//--- tb/tb_int_div_iterative.sv
/*
  Directed and seeded random tests for the iterative divider. Expected
  results come from a model of the division rules, with no divide trap.
*/
`timescale 1ns/1ns
`include "int_div_params.svh"

module tb_int_div_iterative;

  localparam int XLEN = `DIV_XLEN;
  // accepting edge through the edge that raises resp_val
  localparam int LATENCY = XLEN + 1;
  // 3 + 20 unsigned, 5 signed, 3 zero divisor, 4 back-pressure
  localparam int NUM_DIVS = 35;
  localparam int CYCLE_LIMIT = 60 * NUM_DIVS + 100;

  logic                 clk;
  logic                 reset;
  int_div_pkg::div_fn_e req_fn;
  logic [XLEN-1:0]      req_a;
  logic [XLEN-1:0]      req_b;
  logic                 req_val;
  logic                 req_rdy;
  logic [2*XLEN-1:0]    resp_result;
  logic                 resp_val;
  logic                 resp_rdy;

  integer seed = 20;
  int     error_count = 0;
  int     check_count = 0;
  int     cycles = 0;

  int_div_iterative dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // ----------------------------------------------------------------------
  // clock and run limit
  // ----------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles, the DUT stopped responding", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // reference model and compares
  // ----------------------------------------------------------------------

  // remainder in the upper half, quotient in the lower half
  function automatic logic [2*XLEN-1:0] expected_result(
    input int_div_pkg::div_fn_e fn,
    input logic [XLEN-1:0]      a,
    input logic [XLEN-1:0]      b
  );
    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;
    a_neg = (fn == int_div_pkg::DIV_SIGNED) && a[XLEN-1];
    b_neg = (fn == int_div_pkg::DIV_SIGNED) && b[XLEN-1];
    a_mag = a_neg ? -a : a;
    b_mag = b_neg ? -b : b;
    // zero divisor gives all ones quotient and the dividend as remainder
    if (b_mag == '0) begin
      q = '1;
      r = a_mag;
    end else begin
      q = a_mag / b_mag;
      r = a_mag % b_mag;
    end
    // quotient sign by xor and remainder sign from the dividend
    if (a_neg != b_neg) begin
      q = -q;
    end
    if (a_neg) begin
      r = -r;
    end
    return {r, q};
  endfunction

  task automatic check_result(input string name, input logic [2*XLEN-1:0] got,
                              input logic [2*XLEN-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    check_count++;
    if (got != exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // one division entered and left at the drive point after an edge
  // ----------------------------------------------------------------------

  task automatic divide_once(input int_div_pkg::div_fn_e fn, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b, input int hold);
    logic [2*XLEN-1:0] exp;
    int                lat;
    exp     = expected_result(fn, a, b);
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    while (!req_rdy) begin
      @(posedge clk);
      #1;
    end
    // req_rdy high here so the coming edge accepts
    @(posedge clk);
    #1;
    req_val = 1'b0;
    // scramble the request fields after the accept
    req_fn = int_div_pkg::div_fn_e'(~fn);
    req_a  = $random(seed);
    req_b  = $random(seed);
    lat = 1;
    while (!resp_val) begin
      check_flag("req_rdy", req_rdy, 1'b0);
      @(posedge clk);
      #1;
      lat++;
    end
    check_latency("resp_val latency", lat, LATENCY);
    check_flag("req_rdy", req_rdy, 1'b0);
    check_result("resp_result", resp_result, exp);
    // response held back by the sink
    repeat (hold) begin
      @(posedge clk);
      #1;
      check_flag("resp_val", resp_val, 1'b1);
      check_flag("req_rdy", req_rdy, 1'b0);
      check_result("resp_result", resp_result, exp);
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
    check_flag("resp_val", resp_val, 1'b0);
    check_flag("req_rdy", req_rdy, 1'b1);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------

  task automatic reset_values();
    check_flag("req_rdy", req_rdy, 1'b1);
    check_flag("resp_val", resp_val, 1'b0);
  endtask

  task automatic unsigned_cases();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    divide_once(int_div_pkg::DIV_UNSIGNED, 32'd5, 32'd9, 0);
    divide_once(int_div_pkg::DIV_UNSIGNED, 32'hdeadbeef, 32'd1, 0);
    divide_once(int_div_pkg::DIV_UNSIGNED, 32'hffffffff, 32'h10, 0);
    repeat (20) begin
      a = $random(seed);
      b = $random(seed);
      divide_once(int_div_pkg::DIV_UNSIGNED, a, b, 0);
    end
  endtask

  task automatic signed_cases();
    // all four sign pairs
    divide_once(int_div_pkg::DIV_SIGNED, 32'd100, 32'd7, 0);
    divide_once(int_div_pkg::DIV_SIGNED, -32'd100, 32'd7, 0);
    divide_once(int_div_pkg::DIV_SIGNED, 32'd100, -32'd7, 0);
    divide_once(int_div_pkg::DIV_SIGNED, -32'd100, -32'd7, 0);
    // most negative over minus one wraps back to itself
    divide_once(int_div_pkg::DIV_SIGNED, 32'h80000000, 32'hffffffff, 0);
  endtask

  task automatic zero_divisor_cases();
    divide_once(int_div_pkg::DIV_UNSIGNED, 32'd12345, 32'd0, 0);
    divide_once(int_div_pkg::DIV_SIGNED, -32'd12345, 32'd0, 0);
    divide_once(int_div_pkg::DIV_SIGNED, 32'd77, 32'd0, 0);
  endtask

  task automatic back_pressure_cases();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] pick;
    int              hold;
    repeat (4) begin
      a    = $random(seed);
      b    = $random(seed);
      pick = $random(seed);
      hold = $unsigned($random(seed)) % 11;
      divide_once(int_div_pkg::div_fn_e'(pick[0]), a, b, hold);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    reset    = 1'b1;
    req_fn   = int_div_pkg::DIV_UNSIGNED;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_values();
    unsigned_cases();
    signed_cases();
    zero_divisor_cases();
    back_pressure_cases();
    $display("%0d errors in %0d checks", error_count, check_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
logic/int_div_pkg.sv
logic/int_div_dpath.sv
logic/int_div_ctrl.sv
logic/int_div_iterative.sv
tb/tb_int_div_iterative.sv

//--- Bender.yml
package:
  name: int_div_iterative

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/int_div_pkg.sv
      - logic/int_div_dpath.sv
      - logic/int_div_ctrl.sv
      - logic/int_div_iterative.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_int_div_iterative.sv
